// File: build.f
dsp_link_pkg.sv
mcbsp_rx.sv
dsp_cmd_decode.sv
sync_pos_capture.sv
tx_frame_buffer.sv
dsp_fpga_data.sv
tb_chk.sv
tb_checker.sv
tb_dsp_fpga_data.sv

// File: dsp_cmd_decode.sv
module dsp_cmd_decode (
  input  logic                mcbsp0_slaver_clkx,
  input  logic                cfg_rst,
  input  dsp_link_pkg::word_t rx_word,
  input  logic                rx_valid,
  output logic                start_send,
  output dsp_link_pkg::step_t send_step,
  output logic                part_syn_start,
  output logic                lose,
  output logic                flag_croase,
  output logic                flag_fine,
  output logic                croase_data_flag,
  output logic                fine_data_flag,
  output logic                decode_data_flag,
  output logic                tx_data_flag,
  output logic                dsp_start_send
);

  dsp_link_pkg::opcode_t opc;
  logic                  send_start;
  logic                  send_start_d;

  assign opc = dsp_link_pkg::opcode_t'(rx_word);

  // two cycle send request
  assign start_send = send_start || send_start_d;

  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      send_start_d <= 1'b0;
    end else begin
      send_start_d <= send_start;
    end
  end

  ////////////////////////////////////////
  // command decode
  ////////////////////////////////////////
  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      send_start       <= 1'b0;
      send_step        <= '0;
      part_syn_start   <= 1'b0;
      lose             <= 1'b0;
      flag_croase      <= 1'b0;
      flag_fine        <= 1'b0;
      croase_data_flag <= 1'b0;
      fine_data_flag   <= 1'b0;
      decode_data_flag <= 1'b0;
      tx_data_flag     <= 1'b0;
      dsp_start_send   <= 1'b0;
    end else begin
      send_start       <= 1'b0;  // strobes default low
      part_syn_start   <= 1'b0;
      lose             <= 1'b0;
      flag_croase      <= 1'b0;
      flag_fine        <= 1'b0;
      croase_data_flag <= 1'b0;
      fine_data_flag   <= 1'b0;
      decode_data_flag <= 1'b0;
      tx_data_flag     <= 1'b0;
      if (rx_valid) begin
        case (opc)
          dsp_link_pkg::OPC_STEP0, dsp_link_pkg::OPC_STEP1,
          dsp_link_pkg::OPC_STEP2, dsp_link_pkg::OPC_STEP3,
          dsp_link_pkg::OPC_STEP4, dsp_link_pkg::OPC_STEP5,
          dsp_link_pkg::OPC_STEP6, dsp_link_pkg::OPC_STEP7: begin
            send_start <= 1'b1;
            send_step  <= dsp_link_pkg::step_t'(rx_word[2:0]);  // low nibble repeats the step
          end
          dsp_link_pkg::OPC_PART_SYN: begin
            send_start       <= 1'b1;
            send_step        <= '0;
            part_syn_start   <= 1'b1;
            croase_data_flag <= 1'b1;
          end
          dsp_link_pkg::OPC_FINE_DATA: begin  // step left as is
            send_start     <= 1'b1;
            fine_data_flag <= 1'b1;
          end
          dsp_link_pkg::OPC_DECODE_DATA: begin
            send_start       <= 1'b1;
            decode_data_flag <= 1'b1;
          end
          dsp_link_pkg::OPC_LOSE:       lose        <= 1'b1;
          dsp_link_pkg::OPC_COARSE_SYN: flag_croase <= 1'b1;
          dsp_link_pkg::OPC_FINE_SYN:   flag_fine   <= 1'b1;
          dsp_link_pkg::OPC_TX_DATA: begin
            tx_data_flag   <= 1'b1;
            dsp_start_send <= 1'b1;  // stays set until reset
          end
          default: ;  // plain data word
        endcase
      end
    end
  end

endmodule

// File: dsp_fpga_data.sv
module dsp_fpga_data (
  input  logic                    mcbsp0_slaver_clkx,
  input  logic                    cfg_rst,
  input  logic                    mcbsp0_slaver_fsx,
  input  logic                    mcbsp0_slaver_mosi,
  input  dsp_link_pkg::buf_addr_t read_addr,
  output dsp_link_pkg::word_t     send_data,
  output logic                    tx_send_start,
  output logic                    start_send,
  output dsp_link_pkg::step_t     send_step,
  output logic                    part_syn_start,
  output logic                    lose,
  output logic                    corase_end,
  output logic                    fine_end,
  output dsp_link_pkg::word_t     corase_syn_pos,
  output dsp_link_pkg::word_t     fine_syn_pos,
  output logic                    dsp_start_send,
  output logic                    flag_croase,
  output logic                    flag_fine,
  output logic                    croase_data_flag,
  output logic                    fine_data_flag,
  output logic                    decode_data_flag,
  output logic                    tx_data_flag
);

  dsp_link_pkg::word_t rx_word;
  logic                rx_valid;

  ////////////////////////////////////////
  // mcbsp0 slave side
  ////////////////////////////////////////
  mcbsp_rx u_rx (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .fsx                (mcbsp0_slaver_fsx),
    .mosi               (mcbsp0_slaver_mosi),
    .rx_word            (rx_word),
    .rx_valid           (rx_valid)
  );

  dsp_cmd_decode u_decode (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .rx_word            (rx_word),
    .rx_valid           (rx_valid),
    .start_send         (start_send),
    .send_step          (send_step),
    .part_syn_start     (part_syn_start),
    .lose               (lose),
    .flag_croase        (flag_croase),
    .flag_fine          (flag_fine),
    .croase_data_flag   (croase_data_flag),
    .fine_data_flag     (fine_data_flag),
    .decode_data_flag   (decode_data_flag),
    .tx_data_flag       (tx_data_flag),
    .dsp_start_send     (dsp_start_send)
  );

  // slot sync positions
  sync_pos_capture coarse_cap (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .arm                (flag_croase),
    .rx_word            (rx_word),
    .rx_valid           (rx_valid),
    .pos                (corase_syn_pos),
    .end_pulse          (corase_end)
  );

  sync_pos_capture fine_cap (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .arm                (flag_fine),
    .rx_word            (rx_word),
    .rx_valid           (rx_valid),
    .pos                (fine_syn_pos),
    .end_pulse          (fine_end)
  );

  tx_frame_buffer u_buf (
    .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
    .cfg_rst            (cfg_rst),
    .arm                (tx_data_flag),  // frame follows 66669999
    .rx_word            (rx_word),
    .rx_valid           (rx_valid),
    .read_addr          (read_addr),
    .send_data          (send_data),
    .tx_send_start      (tx_send_start)
  );

endmodule

// File: dsp_link_pkg.sv
package dsp_link_pkg;

  ////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////
  localparam int WORD_W      = 32;
  localparam int FRAME_WORDS = 20;  // words per transmit frame
  localparam int BUF_ADDR_W  = 6;   // two 32-word banks
  localparam int BANK1_BASE  = 32;  // bank 0 sits at 0
  localparam int BIT_CNT_W   = 5;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [2:0]            step_t;
  typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

  ////////////////////////////////////////
  // command words from the DSP
  ////////////////////////////////////////
  typedef enum logic [WORD_W-1:0] {
    OPC_STEP0       = 32'hAAAA_0000,
    OPC_STEP1       = 32'hAAAA_1111,
    OPC_STEP2       = 32'hAAAA_2222,
    OPC_STEP3       = 32'hAAAA_3333,
    OPC_STEP4       = 32'hAAAA_4444,
    OPC_STEP5       = 32'hAAAA_5555,
    OPC_STEP6       = 32'hAAAA_6666,
    OPC_STEP7       = 32'hAAAA_7777,
    OPC_PART_SYN    = 32'hAAAA_AAAA,  // part sync, also step 0
    OPC_FINE_DATA   = 32'h6666_6666,
    OPC_DECODE_DATA = 32'h5555_5555,
    OPC_LOSE        = 32'h1111_1111,
    OPC_COARSE_SYN  = 32'h4444_4444,
    OPC_FINE_SYN    = 32'h3333_3333,
    OPC_TX_DATA     = 32'h6666_9999   // a data frame follows
  } opcode_t;

  typedef enum logic {RX_IDLE, RX_SHIFT} rx_state_t;

endpackage

// File: mcbsp_rx.sv
module mcbsp_rx (
  input  logic                mcbsp0_slaver_clkx,
  input  logic                cfg_rst,
  input  logic                fsx,
  input  logic                mosi,
  output dsp_link_pkg::word_t rx_word,
  output logic                rx_valid
);

  typedef logic [dsp_link_pkg::BIT_CNT_W-1:0] cnt_t;

  dsp_link_pkg::rx_state_t state;
  cnt_t                    bit_cnt;  // bits taken after the sync bit

  // msb first, the shift register is the output word
  always_ff @(posedge mcbsp0_slaver_clkx) begin
    if ((state == dsp_link_pkg::RX_SHIFT) || fsx) begin
      rx_word <= {rx_word[dsp_link_pkg::WORD_W-2:0], mosi};
    end
  end

  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      state    <= dsp_link_pkg::RX_IDLE;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        dsp_link_pkg::RX_IDLE: begin
          if (fsx) begin  // bit 31 comes with the sync
            state   <= dsp_link_pkg::RX_SHIFT;
            bit_cnt <= '0;
          end
        end
        dsp_link_pkg::RX_SHIFT: begin
          bit_cnt <= bit_cnt + cnt_t'(1);
          if (int'(bit_cnt) == dsp_link_pkg::WORD_W - 2) begin  // bit 0 now
            state    <= dsp_link_pkg::RX_IDLE;
            rx_valid <= 1'b1;
          end
        end
        default: state <= dsp_link_pkg::RX_IDLE;
      endcase
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_dsp_fpga_data \
  -o sim_tb_dsp_fpga_data \
  && ./obj_dir/sim_tb_dsp_fpga_data +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "STATUS: PASS" sim.log && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// File: sync_pos_capture.sv
module sync_pos_capture (
  input  logic                mcbsp0_slaver_clkx,
  input  logic                cfg_rst,
  input  logic                arm,
  input  dsp_link_pkg::word_t rx_word,
  input  logic                rx_valid,
  output dsp_link_pkg::word_t pos,
  output logic                end_pulse
);

  logic armed;

  // arm strobe lands after the command word, so the
  // next word received is the position
  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      armed <= 1'b0;
    end else if (end_pulse) begin
      armed <= 1'b0;
    end else if (arm) begin
      armed <= 1'b1;
    end
  end

  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      pos       <= '0;
      end_pulse <= 1'b0;
    end else if (armed && rx_valid) begin
      pos       <= rx_word;
      end_pulse <= 1'b1;
    end else begin
      end_pulse <= 1'b0;  // pos holds
    end
  end

endmodule

// File: tb_checker.sv
module tb_checker (
  input logic                    mcbsp0_slaver_clkx,
  input logic                    cfg_rst,
  input logic                    mcbsp0_slaver_fsx,
  input logic                    mcbsp0_slaver_mosi,
  input dsp_link_pkg::buf_addr_t read_addr,
  input dsp_link_pkg::word_t     send_data,
  input logic                    tx_send_start,
  input logic                    start_send,
  input dsp_link_pkg::step_t     send_step,
  input logic                    part_syn_start,
  input logic                    lose,
  input logic                    corase_end,
  input logic                    fine_end,
  input dsp_link_pkg::word_t     corase_syn_pos,
  input dsp_link_pkg::word_t     fine_syn_pos,
  input logic                    dsp_start_send,
  input logic                    flag_croase,
  input logic                    flag_fine,
  input logic                    croase_data_flag,
  input logic                    fine_data_flag,
  input logic                    decode_data_flag,
  input logic                    tx_data_flag
);

  int test_checks = 0;
  int test_errs = 0;
  int total_checks = 0;
  int total_errs = 0;
  int n_tests = 0;

  // serial side of the model
  logic        m_shift;
  int          m_cnt;
  logic [31:0] m_sh;
  logic        m_valid;  // expected rx_valid
  logic [31:0] m_word;

  // expected outputs after the last edge
  logic        e_dss, e_tss;
  int          e_send_left;  // cycles of start_send still to come
  logic [2:0]  e_step;
  logic        e_part, e_lose, e_fcro, e_ffine, e_cdf, e_fdf, e_ddf, e_txf;
  logic        e_cend, e_fend, c_armed, f_armed;
  logic [31:0] e_cpos, e_fpos, e_rdata;
  logic        e_send_en, rd_known, e_bank;
  int          e_ptr;
  int          frame_cnt;
  logic [31:0] m_mem [64];
  logic        m_known [64];

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    test_checks++;
    if (got !== exp) begin
      test_errs++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %-7s %0d checks, %0d errors", name, test_checks, test_errs);
    total_checks += test_checks;
    total_errs   += test_errs;
    n_tests++;
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic report_totals();
    $display("%0d tests, %0d checks, %0d errors", n_tests, total_checks, total_errs);
  endtask

  task automatic reset_model();
    m_shift = 1'b0;
    m_valid = 1'b0;
    {e_dss, e_tss, e_step} = '0;
    e_send_left = 0;
    {e_part, e_lose, e_fcro, e_ffine, e_cdf, e_fdf, e_ddf, e_txf} = '0;
    {e_cend, e_fend, c_armed, f_armed, e_send_en, rd_known, e_bank} = '0;
    e_cpos    = '0;
    e_fpos    = '0;
    e_ptr     = 0;
    frame_cnt = 0;
    for (int a = 0; a < 64; a++) m_known[a] = 1'b0;
  endtask

  task automatic compare_outputs();
    check("start_send", 32'(start_send), 32'(e_send_left != 0));
    check("send_step", 32'(send_step), 32'(e_step));
    check("part_syn_start", 32'(part_syn_start), 32'(e_part));
    check("lose", 32'(lose), 32'(e_lose));
    check("flag_croase", 32'(flag_croase), 32'(e_fcro));
    check("flag_fine", 32'(flag_fine), 32'(e_ffine));
    check("croase_data_flag", 32'(croase_data_flag), 32'(e_cdf));
    check("fine_data_flag", 32'(fine_data_flag), 32'(e_fdf));
    check("decode_data_flag", 32'(decode_data_flag), 32'(e_ddf));
    check("tx_data_flag", 32'(tx_data_flag), 32'(e_txf));
    check("dsp_start_send", 32'(dsp_start_send), 32'(e_dss));
    check("corase_end", 32'(corase_end), 32'(e_cend));
    check("fine_end", 32'(fine_end), 32'(e_fend));
    check("corase_syn_pos", corase_syn_pos, e_cpos);
    check("fine_syn_pos", fine_syn_pos, e_fpos);
    check("tx_send_start", 32'(tx_send_start), 32'(e_tss));
    if (rd_known) check("send_data", send_data, e_rdata);  // unwritten words skipped
  endtask

  task automatic decode_word(input logic [31:0] w);
    for (int s = 0; s < 8; s++) begin
      if (w == 32'hAAAA_0000 + 32'h1111 * s) begin  // step n repeats n in each nibble
        e_send_left = 2;
        e_step      = 3'(s);
      end
    end
    case (w)
      dsp_link_pkg::OPC_PART_SYN: begin
        e_send_left = 2;
        e_step      = 3'd0;
        e_part      = 1'b1;
        e_cdf       = 1'b1;
      end
      dsp_link_pkg::OPC_FINE_DATA: begin
        e_send_left = 2;
        e_fdf       = 1'b1;
      end
      dsp_link_pkg::OPC_DECODE_DATA: begin
        e_send_left = 2;
        e_ddf       = 1'b1;
      end
      dsp_link_pkg::OPC_LOSE:       e_lose  = 1'b1;
      dsp_link_pkg::OPC_COARSE_SYN: e_fcro  = 1'b1;
      dsp_link_pkg::OPC_FINE_SYN:   e_ffine = 1'b1;
      dsp_link_pkg::OPC_TX_DATA: begin
        e_txf = 1'b1;
        e_dss = 1'b1;
      end
      default: ;
    endcase
  endtask

  ////////////////////////////////////////
  // one clock edge of the reference model
  ////////////////////////////////////////
  task automatic step_model();
    logic wr;
    logic n_cend;
    logic n_fend;
    wr       = e_send_en && m_valid;
    e_rdata  = m_mem[read_addr];  // old contents on a same-edge write
    rd_known = m_known[read_addr];
    if (wr) begin
      m_mem[e_ptr]   = m_word;
      m_known[e_ptr] = 1'b1;
    end
    if (e_tss) e_send_en = 1'b0;
    else if (e_txf) e_send_en = 1'b1;
    e_tss = wr && (frame_cnt == dsp_link_pkg::FRAME_WORDS - 1);
    if (e_tss) begin
      frame_cnt = 0;
      e_bank    = ~e_bank;  // frames alternate banks
      e_ptr     = e_bank ? dsp_link_pkg::BANK1_BASE : 0;
    end else if (wr) begin
      frame_cnt++;
      e_ptr++;
    end
    // sync captures
    n_cend = c_armed && m_valid;
    n_fend = f_armed && m_valid;
    if (n_cend) e_cpos = m_word;
    if (n_fend) e_fpos = m_word;
    if (e_cend) c_armed = 1'b0;
    else if (e_fcro) c_armed = 1'b1;
    if (e_fend) f_armed = 1'b0;
    else if (e_ffine) f_armed = 1'b1;
    e_cend   = n_cend;
    e_fend   = n_fend;
    // decoder
    if (e_send_left > 0) e_send_left--;
    {e_part, e_lose, e_fcro, e_ffine, e_cdf, e_fdf, e_ddf, e_txf} = '0;
    if (m_valid) decode_word(m_word);
    // deserialiser last so the units above see the old valid
    m_valid = 1'b0;
    if (m_shift) begin
      m_sh = {m_sh[30:0], mcbsp0_slaver_mosi};
      m_cnt++;
      if (m_cnt == 32) begin
        m_shift = 1'b0;
        m_valid = 1'b1;
        m_word  = m_sh;
      end
    end else if (mcbsp0_slaver_fsx) begin
      m_shift = 1'b1;
      m_cnt   = 1;
      m_sh    = {31'b0, mcbsp0_slaver_mosi};  // bit 31 rides with the sync
    end
  endtask

  always @(posedge mcbsp0_slaver_clkx) begin
    if (cfg_rst) begin
      reset_model();
    end else begin
      compare_outputs();
      step_model();
    end
  end

endmodule

// File: tb_chk.sv
module tb_chk (
  input logic                    mcbsp0_slaver_clkx,
  input logic                    cfg_rst,
  input logic                    rx_valid,
  input logic                    start_send,
  input logic                    tx_send_start,
  input dsp_link_pkg::buf_addr_t wr_ptr
);

  int fails = 0;  // read by the testbench top

  // send request is two cycles wide, never three
  a_start_len: assert property (@(posedge mcbsp0_slaver_clkx) disable iff (cfg_rst)
    !(start_send && $past(start_send) && $past(start_send, 2)))
    else begin
      fails++;
      $error("start_send high for three cycles");
    end

  a_bank_base: assert property (@(posedge mcbsp0_slaver_clkx) disable iff (cfg_rst)
    tx_send_start |=> (wr_ptr == '0 ||
                       wr_ptr == dsp_link_pkg::buf_addr_t'(dsp_link_pkg::BANK1_BASE)))
    else begin
      fails++;
      $error("write pointer not at a bank base after frame end");
    end

  a_valid_gap: assert property (@(posedge mcbsp0_slaver_clkx) disable iff (cfg_rst)
    !(rx_valid && $past(rx_valid)))
    else begin
      fails++;
      $error("rx_valid high in two consecutive cycles");
    end

endmodule

bind dsp_cmd_decode tb_chk chk_dec (
  .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
  .cfg_rst            (cfg_rst),
  .rx_valid           (rx_valid),
  .start_send         (start_send),
  .tx_send_start      (1'b0),
  .wr_ptr             ('0)
);

bind tx_frame_buffer tb_chk chk_buf (
  .mcbsp0_slaver_clkx (mcbsp0_slaver_clkx),
  .cfg_rst            (cfg_rst),
  .rx_valid           (rx_valid),
  .start_send         (1'b0),
  .tx_send_start      (tx_send_start),
  .wr_ptr             (wr_ptr)
);

// File: tb_dsp_fpga_data.sv
module tb_dsp_fpga_data;

  localparam logic [31:0] LFSR_SEED = 32'hee00;
  localparam int WORDS_SENT     = 104;  // all words of all tests
  localparam int READ_CYCLES    = 70;
  localparam int TIMEOUT_CYCLES = WORDS_SENT * 42 + READ_CYCLES + 200;

  logic                    mcbsp0_slaver_clkx;
  logic                    cfg_rst;
  logic                    mcbsp0_slaver_fsx;
  logic                    mcbsp0_slaver_mosi;
  dsp_link_pkg::buf_addr_t read_addr;
  dsp_link_pkg::word_t     send_data;
  dsp_link_pkg::word_t     corase_syn_pos;
  dsp_link_pkg::word_t     fine_syn_pos;
  dsp_link_pkg::step_t     send_step;
  logic tx_send_start, start_send, part_syn_start, lose, corase_end, fine_end;
  logic dsp_start_send, flag_croase, flag_fine, croase_data_flag;
  logic fine_data_flag, decode_data_flag, tx_data_flag;
  logic [31:0]             lfsr;
  int                      cycles;

  dsp_fpga_data dut (.*);

  tb_checker chk (.*);

  initial begin
    mcbsp0_slaver_clkx = 1'b0;
    forever #20 mcbsp0_slaver_clkx = ~mcbsp0_slaver_clkx;
  end

  ////////////////////////////////////////
  // random source
  ////////////////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic rand_data(output logic [31:0] w);
    take_bits(32, w);
    // flipping bit 31 moves any command nibble to a free one
    if (w[31:28] inside {4'hA, 4'h6, 4'h5, 4'h4, 4'h3, 4'h1}) w[31] = ~w[31];
  endtask

  ////////////////////////////////////////
  // serial link driver
  ////////////////////////////////////////
  task automatic send_word(input logic [31:0] w);
    for (int i = 31; i >= 0; i--) begin
      @(negedge mcbsp0_slaver_clkx);
      mcbsp0_slaver_fsx  = (i == 31);
      mcbsp0_slaver_mosi = w[i];
    end
    @(negedge mcbsp0_slaver_clkx);  // first idle cycle
    mcbsp0_slaver_fsx  = 1'b0;
    mcbsp0_slaver_mosi = 1'b0;
  endtask

  task automatic idle_gap();
    logic [31:0] n;
    take_bits(3, n);
    repeat (n) @(negedge mcbsp0_slaver_clkx);
  endtask

  task automatic send_with_gap(input logic [31:0] w);
    send_word(w);
    idle_gap();
  endtask

  task automatic noise_word();
    logic [31:0] w;
    rand_data(w);
    send_with_gap(w);
  endtask

  task automatic wait_frame_end();
    @(negedge mcbsp0_slaver_clkx);
    while (!tx_send_start) @(negedge mcbsp0_slaver_clkx);
  endtask

  task automatic finish_test(input string name);
    repeat (4) @(negedge mcbsp0_slaver_clkx);  // let the last strobes drain
    chk.report_test(name);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    lfsr               = LFSR_SEED;
    cfg_rst            = 1'b1;
    mcbsp0_slaver_fsx  = 1'b0;
    mcbsp0_slaver_mosi = 1'b0;
    read_addr          = '0;
    repeat (5) @(negedge mcbsp0_slaver_clkx);
    cfg_rst = 1'b0;

    for (int i = 0; i < 12; i++) begin
      take_bits(4, r);
      if (r[3:2] == 2'b11) w = dsp_link_pkg::OPC_PART_SYN;
      else w = 32'hAAAA_0000 + {29'b0, r[2:0]} * 32'h1111;
      send_with_gap(w);
      noise_word();
    end
    finish_test("steps");

    for (int i = 0; i < 9; i++) begin
      take_bits(2, r);
      case (r[1:0])
        2'd0:    w = dsp_link_pkg::OPC_LOSE;
        2'd1:    w = dsp_link_pkg::OPC_FINE_DATA;
        default: w = dsp_link_pkg::OPC_DECODE_DATA;
      endcase
      send_with_gap(w);
      noise_word();
    end
    finish_test("markers");

    for (int i = 0; i < 6; i++) begin
      take_bits(1, r);
      send_with_gap(r[0] ? dsp_link_pkg::OPC_FINE_SYN : dsp_link_pkg::OPC_COARSE_SYN);
      noise_word();  // the position word
    end
    finish_test("sync");

    for (int i = 0; i < 8; i++) noise_word();
    finish_test("noise");

    // two frames, bank 0 then bank 1
    for (int f = 0; f < 2; f++) begin
      send_with_gap(dsp_link_pkg::OPC_TX_DATA);
      for (int k = 0; k < dsp_link_pkg::FRAME_WORDS - 1; k++) noise_word();
      rand_data(w);
      send_word(w);
      wait_frame_end();
    end
    for (int a = 0; a < 64; a++) begin
      @(negedge mcbsp0_slaver_clkx);
      read_addr = dsp_link_pkg::buf_addr_t'(a);
    end
    finish_test("frames");

    chk.report_totals();
    if (chk.total_errs == 0 && dut.u_decode.chk_dec.fails == 0 &&
        dut.u_buf.chk_buf.fails == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge mcbsp0_slaver_clkx);
      cycles++;
    end
    $display("timeout: test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: tx_frame_buffer.sv
module tx_frame_buffer (
  input  logic                    mcbsp0_slaver_clkx,
  input  logic                    cfg_rst,
  input  logic                    arm,
  input  dsp_link_pkg::word_t     rx_word,
  input  logic                    rx_valid,
  input  dsp_link_pkg::buf_addr_t read_addr,
  output dsp_link_pkg::word_t     send_data,
  output logic                    tx_send_start
);

  dsp_link_pkg::word_t     mem [0:(1 << dsp_link_pkg::BUF_ADDR_W)-1];
  dsp_link_pkg::buf_addr_t wr_ptr;
  dsp_link_pkg::buf_addr_t next_base;
  logic                    send_en;
  logic                    wr_en;
  logic                    frame_done;

  assign wr_en = send_en && rx_valid;

  // last word slot of either bank
  assign frame_done =
    (wr_ptr == dsp_link_pkg::buf_addr_t'(dsp_link_pkg::FRAME_WORDS - 1)) ||
    (wr_ptr == dsp_link_pkg::buf_addr_t'(dsp_link_pkg::BANK1_BASE +
                                         dsp_link_pkg::FRAME_WORDS - 1));

  assign next_base = (wr_ptr < dsp_link_pkg::buf_addr_t'(dsp_link_pkg::BANK1_BASE)) ?
                     dsp_link_pkg::buf_addr_t'(dsp_link_pkg::BANK1_BASE) : '0;

  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      send_en <= 1'b0;
    end else if (tx_send_start) begin  // frame closed
      send_en <= 1'b0;
    end else if (arm) begin
      send_en <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // ping-pong write pointer
  ////////////////////////////////////////
  always_ff @(posedge mcbsp0_slaver_clkx or posedge cfg_rst) begin
    if (cfg_rst) begin
      wr_ptr        <= '0;
      tx_send_start <= 1'b0;
    end else if (wr_en && frame_done) begin
      wr_ptr        <= next_base;  // swap banks
      tx_send_start <= 1'b1;
    end else if (wr_en) begin
      wr_ptr        <= wr_ptr + dsp_link_pkg::buf_addr_t'(1);
      tx_send_start <= 1'b0;
    end else begin
      tx_send_start <= 1'b0;
    end
  end

  always_ff @(posedge mcbsp0_slaver_clkx) begin
    if (wr_en) begin
      mem[wr_ptr] <= rx_word;
    end
    send_data <= mem[read_addr];  // one cycle read
  end

endmodule
